/* design/asym_converter.sv */
`include "asym_fifo_macros.svh"

module asym_converter
  import asym_fifo_pkg::*;
#(
  parameter int W_DATA_W = `ASYM_W_DATA_W,
  parameter int R_DATA_W = `ASYM_R_DATA_W,
  parameter int ADDR_W = `ASYM_ADDR_W,
  localparam int MAXDATA_W = `ASYM_MAX(W_DATA_W, R_DATA_W),
  localparam int MINDATA_W = `ASYM_MIN(W_DATA_W, R_DATA_W),
  localparam int R = MAXDATA_W / MINDATA_W,
  localparam int MINADDR_W = ADDR_W - $clog2(R),
  localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
  localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // write port
  input  logic                 w_en_i,
  input  logic [W_ADDR_W-1:0]  w_addr_i,
  input  logic [W_DATA_W-1:0]  w_data_i,
  // read port
  input  logic                 r_en_i,
  input  logic [R_ADDR_W-1:0]  r_addr_i,
  output logic [R_DATA_W-1:0]  r_data_o,
  // lane memory side
  output logic [R-1:0]         mem_w_en_o,
  output logic [MINADDR_W-1:0] mem_w_addr_o,
  output logic [MAXDATA_W-1:0] mem_w_data_o,
  output logic [R-1:0]         mem_r_en_o,
  output logic [MINADDR_W-1:0] mem_r_addr_o,
  input  logic [MAXDATA_W-1:0] mem_r_data_i
);

  if (W_DATA_W > R_DATA_W) begin : g_write_wide
    localparam int LSB_W = $clog2(R);

    logic [LSB_W-1:0]     r_lane;
    logic [LSB_W-1:0]     r_lane_q;
    logic [MAXDATA_W-1:0] r_shifted;

    // wide write covers the whole row
    assign mem_w_en_o = {R{w_en_i}};
    assign mem_w_addr_o = w_addr_i;
    assign mem_w_data_o = w_data_i;

    // narrow read picks one lane from the low address bits
    assign r_lane = r_addr_i[LSB_W-1:0];
    assign mem_r_en_o = {{(R - 1){1'b0}}, r_en_i} << r_lane;
    assign mem_r_addr_o = r_addr_i[R_ADDR_W-1:LSB_W];

    // lane index follows the memory read by one cycle
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        r_lane_q <= '0;
      end else if (r_en_i) begin
        r_lane_q <= r_lane;
      end
    end

    assign r_shifted = mem_r_data_i >> (r_lane_q * R_DATA_W);
    assign r_data_o = r_shifted[R_DATA_W-1:0];

    a_r_lane_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(mem_r_en_o));

  end else if (W_DATA_W < R_DATA_W) begin : g_read_wide
    localparam int LSB_W = $clog2(R);

    logic [LSB_W-1:0] w_lane;

    // narrow write lands in one lane, data shifted into place
    assign w_lane = w_addr_i[LSB_W-1:0];
    assign mem_w_en_o = {{(R - 1){1'b0}}, w_en_i} << w_lane;
    assign mem_w_data_o = {{(R_DATA_W - W_DATA_W){1'b0}}, w_data_i} << (w_lane * W_DATA_W);
    assign mem_w_addr_o = w_addr_i[W_ADDR_W-1:LSB_W];

    // wide read takes every lane
    assign mem_r_en_o = {R{r_en_i}};
    assign mem_r_addr_o = r_addr_i;
    assign r_data_o = mem_r_data_i;

    a_w_lane_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(mem_w_en_o));

  end else begin : g_equal
    // single lane, straight through
    assign mem_w_en_o = w_en_i;
    assign mem_w_addr_o = w_addr_i;
    assign mem_w_data_o = w_data_i;
    assign mem_r_en_o = r_en_i;
    assign mem_r_addr_o = r_addr_i;
    assign r_data_o = mem_r_data_i;
  end

endmodule

/* design/asym_fifo_macros.svh */
`ifndef ASYM_FIFO_MACROS_SVH
`define ASYM_FIFO_MACROS_SVH

// port widths of the two clients
`define ASYM_W_DATA_W 16
`define ASYM_R_DATA_W 8

// narrow-side address width, 16 narrow units deep
`define ASYM_ADDR_W 4

`define ASYM_MAX(a, b) (((a) > (b)) ? (a) : (b))
`define ASYM_MIN(a, b) (((a) < (b)) ? (a) : (b))

`define ASYM_MAXDATA_W `ASYM_MAX(`ASYM_W_DATA_W, `ASYM_R_DATA_W)
`define ASYM_MINDATA_W `ASYM_MIN(`ASYM_W_DATA_W, `ASYM_R_DATA_W)
`define ASYM_RATIO (`ASYM_MAXDATA_W / `ASYM_MINDATA_W)

// depth exponent of one lane
`define ASYM_MINADDR_W (`ASYM_ADDR_W - $clog2(`ASYM_RATIO))

// the wide side addresses whole rows, the narrow side single lanes
`define ASYM_W_ADDR_W ((`ASYM_W_DATA_W == `ASYM_MAXDATA_W) ? `ASYM_MINADDR_W : `ASYM_ADDR_W)
`define ASYM_R_ADDR_W ((`ASYM_R_DATA_W == `ASYM_MAXDATA_W) ? `ASYM_MINADDR_W : `ASYM_ADDR_W)

`define ASYM_W_UNITS (`ASYM_W_DATA_W / `ASYM_MINDATA_W)
`define ASYM_R_UNITS (`ASYM_R_DATA_W / `ASYM_MINDATA_W)

`endif

/* design/asym_fifo_pkg.sv */
`include "asym_fifo_macros.svh"

package asym_fifo_pkg;

  // write handshake FSM
  typedef enum logic [1:0] {
    W_IDLE,
    W_COMMIT,
    W_ACK
  } write_state_e;

  // read handshake FSM
  typedef enum logic [1:0] {
    R_IDLE,
    R_FETCH,
    R_CAPTURE,
    R_ACK
  } read_state_e;

  // occupancy in narrow units, extra bit so that a full FIFO fits
  typedef logic [`ASYM_ADDR_W:0] level_t;

endpackage

/* design/asym_fifo_top.sv */
`include "asym_fifo_macros.svh"

module asym_fifo_top
  import asym_fifo_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      wr_req_i,
  input  logic [`ASYM_W_DATA_W-1:0] wr_data_i,
  input  logic                      rd_req_i,
  output logic                      wr_ack_o,
  output logic                      rd_ack_o,
  output logic [`ASYM_R_DATA_W-1:0] rd_data_o,
  output logic                      full_o,
  output logic                      empty_o
);

  // write control to converter
  logic                       w_en;
  logic [`ASYM_W_ADDR_W-1:0]  w_addr;
  logic [`ASYM_W_DATA_W-1:0]  w_data;
  logic                       wr_commit;

  // read control to converter
  logic                       r_en;
  logic [`ASYM_R_ADDR_W-1:0]  r_addr;
  logic [`ASYM_R_DATA_W-1:0]  r_data;
  logic                       rd_commit;

  // converter to lanes
  logic [`ASYM_RATIO-1:0]     mem_w_en;
  logic [`ASYM_MINADDR_W-1:0] mem_w_addr;
  logic [`ASYM_MAXDATA_W-1:0] mem_w_data;
  logic [`ASYM_RATIO-1:0]     mem_r_en;
  logic [`ASYM_MINADDR_W-1:0] mem_r_addr;
  logic [`ASYM_MAXDATA_W-1:0] mem_r_data;

  fifo_write_ctrl fifo_write_ctrl_i (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .wr_req_i(wr_req_i),
    .wr_data_i(wr_data_i),
    .full_i(full_o),
    .wr_ack_o(wr_ack_o),
    .w_en_o(w_en),
    .w_addr_o(w_addr),
    .w_data_o(w_data),
    .wr_commit_o(wr_commit)
  );

  asym_converter #(
    .W_DATA_W(`ASYM_W_DATA_W),
    .R_DATA_W(`ASYM_R_DATA_W),
    .ADDR_W(`ASYM_ADDR_W)
  ) asym_converter_i (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .w_en_i(w_en),
    .w_addr_i(w_addr),
    .w_data_i(w_data),
    .r_en_i(r_en),
    .r_addr_i(r_addr),
    .r_data_o(r_data),
    .mem_w_en_o(mem_w_en),
    .mem_w_addr_o(mem_w_addr),
    .mem_w_data_o(mem_w_data),
    .mem_r_en_o(mem_r_en),
    .mem_r_addr_o(mem_r_addr),
    .mem_r_data_i(mem_r_data)
  );

  lane_ram lane_ram_i (
    .clk_i(clk_i),
    .w_en_i(mem_w_en),
    .w_addr_i(mem_w_addr),
    .w_data_i(mem_w_data),
    .r_en_i(mem_r_en),
    .r_addr_i(mem_r_addr),
    .r_data_o(mem_r_data)
  );

  fifo_read_ctrl fifo_read_ctrl_i (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .rd_req_i(rd_req_i),
    .empty_i(empty_o),
    .r_data_i(r_data),
    .rd_ack_o(rd_ack_o),
    .rd_data_o(rd_data_o),
    .r_en_o(r_en),
    .r_addr_o(r_addr),
    .rd_commit_o(rd_commit)
  );

  fifo_level fifo_level_i (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .wr_commit_i(wr_commit),
    .rd_commit_i(rd_commit),
    .full_o(full_o),
    .empty_o(empty_o)
  );

endmodule

/* design/fifo_level.sv */
`include "asym_fifo_macros.svh"

module fifo_level
  import asym_fifo_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic wr_commit_i,
  input  logic rd_commit_i,
  output logic full_o,
  output logic empty_o
);

  localparam level_t DEPTH = level_t'(1 << `ASYM_ADDR_W);
  localparam level_t W_UNITS = level_t'(`ASYM_W_UNITS);
  localparam level_t R_UNITS = level_t'(`ASYM_R_UNITS);

  level_t level_q;
  level_t level_d;

  // both commits may land on the same edge
  always_comb begin
    level_d = level_q;
    if (wr_commit_i) begin
      level_d = level_d + W_UNITS;
    end
    if (rd_commit_i) begin
      level_d = level_d - R_UNITS;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      level_q <= '0;
    end else begin
      level_q <= level_d;
    end
  end

  // full when another wide word would not fit
  assign full_o = (DEPTH - level_q) < W_UNITS;
  assign empty_o = level_q < R_UNITS;

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_commit_i |=> level_q <= DEPTH);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_commit_i |-> level_q + (wr_commit_i ? W_UNITS : '0) >= R_UNITS);

endmodule

/* design/fifo_read_ctrl.sv */
`include "asym_fifo_macros.svh"

module fifo_read_ctrl
  import asym_fifo_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      rd_req_i,
  input  logic                      empty_i,
  input  logic [`ASYM_R_DATA_W-1:0] r_data_i,
  output logic                      rd_ack_o,
  output logic [`ASYM_R_DATA_W-1:0] rd_data_o,
  output logic                      r_en_o,
  output logic [`ASYM_R_ADDR_W-1:0] r_addr_o,
  output logic                      rd_commit_o
);

  read_state_e               state_q;
  read_state_e               state_d;
  logic [`ASYM_R_ADDR_W-1:0] rptr_q;
  logic [`ASYM_R_DATA_W-1:0] rd_data_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      R_IDLE: begin
        // nothing to hand out while empty
        if (rd_req_i && !empty_i) begin
          state_d = R_FETCH;
        end
      end
      R_FETCH: state_d = R_CAPTURE;
      R_CAPTURE: state_d = R_ACK;
      R_ACK: begin
        if (!rd_req_i) begin
          state_d = R_IDLE;
        end
      end
      default: state_d = R_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= R_IDLE;
      rptr_q <= '0;
    end else begin
      state_q <= state_d;
      // pointer moves as soon as the fetch is issued
      if (state_q == R_FETCH) begin
        rptr_q <= rptr_q + 1'b1;
      end
    end
  end

  // converter output is valid one cycle after the fetch
  always_ff @(posedge clk_i) begin
    if (state_q == R_CAPTURE) begin
      rd_data_q <= r_data_i;
    end
  end

  assign r_en_o = (state_q == R_FETCH);
  assign rd_commit_o = (state_q == R_FETCH);
  assign r_addr_o = rptr_q;
  assign rd_data_o = rd_data_q;
  assign rd_ack_o = (state_q == R_ACK);

  // ack, and the data with it, stays up while the client still asks
  a_ack_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_ack_o && rd_req_i |=> rd_ack_o && $stable(rd_data_o));

endmodule

/* design/fifo_write_ctrl.sv */
`include "asym_fifo_macros.svh"

module fifo_write_ctrl
  import asym_fifo_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      wr_req_i,
  input  logic [`ASYM_W_DATA_W-1:0] wr_data_i,
  input  logic                      full_i,
  output logic                      wr_ack_o,
  output logic                      w_en_o,
  output logic [`ASYM_W_ADDR_W-1:0] w_addr_o,
  output logic [`ASYM_W_DATA_W-1:0] w_data_o,
  output logic                      wr_commit_o
);

  write_state_e              state_q;
  write_state_e              state_d;
  logic [`ASYM_W_ADDR_W-1:0] wptr_q;
  logic [`ASYM_W_DATA_W-1:0] data_q;
  logic                      accept;

  // full holds the request off in idle
  assign accept = (state_q == W_IDLE) && wr_req_i && !full_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      W_IDLE: begin
        if (accept) begin
          state_d = W_COMMIT;
        end
      end
      W_COMMIT: state_d = W_ACK;
      W_ACK: begin
        // wait for the client to drop req
        if (!wr_req_i) begin
          state_d = W_IDLE;
        end
      end
      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= W_IDLE;
      wptr_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == W_COMMIT) begin
        wptr_q <= wptr_q + 1'b1;
      end
    end
  end

  // word held from accept through commit
  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= wr_data_i;
    end
  end

  assign w_en_o = (state_q == W_COMMIT);
  assign wr_commit_o = (state_q == W_COMMIT);
  assign w_addr_o = wptr_q;
  assign w_data_o = data_q;
  assign wr_ack_o = (state_q == W_ACK);

  // level can only drop between accept and commit
  a_no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_en_o |-> !full_i);

endmodule

/* design/lane_ram.sv */
`include "asym_fifo_macros.svh"

module lane_ram (
  input  logic                       clk_i,
  input  logic [`ASYM_RATIO-1:0]     w_en_i,
  input  logic [`ASYM_MINADDR_W-1:0] w_addr_i,
  input  logic [`ASYM_MAXDATA_W-1:0] w_data_i,
  input  logic [`ASYM_RATIO-1:0]     r_en_i,
  input  logic [`ASYM_MINADDR_W-1:0] r_addr_i,
  output logic [`ASYM_MAXDATA_W-1:0] r_data_o
);

  localparam int LANES = `ASYM_RATIO;
  localparam int LANE_W = `ASYM_MINDATA_W;
  localparam int DEPTH = 1 << `ASYM_MINADDR_W;

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    logic [LANE_W-1:0] mem [DEPTH];
    logic [LANE_W-1:0] rd_q;

    // lane write
    always_ff @(posedge clk_i) begin
      if (w_en_i[l]) begin
        mem[w_addr_i] <= w_data_i[l*LANE_W +: LANE_W];
      end
    end

    // registered read, holds the last word when idle
    always_ff @(posedge clk_i) begin
      if (r_en_i[l]) begin
        rd_q <= mem[r_addr_i];
      end
    end

    assign r_data_o[l*LANE_W +: LANE_W] = rd_q;
  end

endmodule

/* filelist.f */
+incdir+design
design/asym_fifo_pkg.sv
design/asym_converter.sv
design/lane_ram.sv
design/fifo_write_ctrl.sv
design/fifo_read_ctrl.sv
design/fifo_level.sv
design/asym_fifo_top.sv
verif/asym_fifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module asym_fifo_tb \
  -f filelist.f

status=0
sim_out=$(./obj_dir/Vasym_fifo_tb 2>&1) || status=$?
echo "$sim_out"

if grep -q "TESTS PASSED" <<< "$sim_out"; then
  exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1

/* verif/asym_fifo_tb.sv */
`include "asym_fifo_macros.svh"

module asym_fifo_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 100;
  localparam int HOLD_CYCLES = 50;
  localparam int RANDOM_OPS = 200;
  localparam int DEPTH_UNITS = 1 << `ASYM_ADDR_W;
  localparam int W_UNITS = `ASYM_W_UNITS;
  localparam int R_W = `ASYM_R_DATA_W;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      wr_req_i;
  logic [`ASYM_W_DATA_W-1:0] wr_data_i;
  logic                      rd_req_i;
  logic                      wr_ack_o;
  logic                      rd_ack_o;
  logic [`ASYM_R_DATA_W-1:0] rd_data_o;
  logic                      full_o;
  logic                      empty_o;

  // bytes in the order they must come out
  logic [R_W-1:0] byte_q[$];

  asym_fifo_top asym_fifo_top_i (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .wr_req_i(wr_req_i),
    .wr_data_i(wr_data_i),
    .rd_req_i(rd_req_i),
    .wr_ack_o(wr_ack_o),
    .rd_ack_o(rd_ack_o),
    .rd_data_o(rd_data_o),
    .full_o(full_o),
    .empty_o(empty_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic fail_run();
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  // inputs change and outputs are sampled 1 ns after the edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [R_W-1:0] got,
                            input logic [R_W-1:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      fail_run();
    end
  endtask

  // full when another write word would not fit and empty when no byte is left
  task automatic check_flags();
    int free_units;
    free_units = DEPTH_UNITS - byte_q.size();
    check_bit("full_o", full_o, free_units < W_UNITS);
    check_bit("empty_o", empty_o, byte_q.size() == 0);
  endtask

  task automatic wait_ack(input bit wr_side, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (((wr_side ? wr_ack_o : rd_ack_o) !== level) && cycles < TIMEOUT_CYCLES) begin
      step();
      cycles++;
    end
    assert ((wr_side ? wr_ack_o : rd_ack_o) === level) else begin
      $display("Timeout at %0t ns: %s did not happen within %0d cycles",
               $time, what, TIMEOUT_CYCLES);
      fail_run();
    end
  endtask

  task automatic write_word(input logic [`ASYM_W_DATA_W-1:0] data);
    wr_data_i = data;
    wr_req_i = 1'b1;
    wait_ack(1'b1, 1'b1, "write ack rise");
    // low byte sits in lane 0 and leaves first
    for (int i = 0; i < W_UNITS; i++) begin
      byte_q.push_back(data[i*R_W +: R_W]);
    end
    wr_req_i = 1'b0;
    wait_ack(1'b1, 1'b0, "write ack fall");
    check_flags();
  endtask

  task automatic read_word();
    logic [R_W-1:0] exp;
    assert (byte_q.size() > 0) else begin
      $display("Read attempted at %0t ns with nothing left to expect", $time);
      fail_run();
    end
    rd_req_i = 1'b1;
    wait_ack(1'b0, 1'b1, "read ack rise");
    exp = byte_q.pop_front();
    check_byte("rd_data_o", rd_data_o, exp);
    rd_req_i = 1'b0;
    wait_ack(1'b0, 1'b0, "read ack fall");
    check_flags();
  endtask

  task automatic expect_no_write_ack(input logic [`ASYM_W_DATA_W-1:0] data);
    wr_data_i = data;
    wr_req_i = 1'b1;
    repeat (HOLD_CYCLES) begin
      step();
      check_bit("wr_ack_o", wr_ack_o, 1'b0);
    end
    wr_req_i = 1'b0;
    step();
    check_flags();
  endtask

  task automatic expect_no_read_ack();
    rd_req_i = 1'b1;
    repeat (HOLD_CYCLES) begin
      step();
      check_bit("rd_ack_o", rd_ack_o, 1'b0);
    end
    rd_req_i = 1'b0;
    step();
    check_flags();
  endtask

  task automatic test_reset_state();
    check_bit("wr_ack_o", wr_ack_o, 1'b0);
    check_bit("rd_ack_o", rd_ack_o, 1'b0);
    check_flags();
    expect_no_read_ack();
  endtask

  task automatic test_single_word();
    write_word(16'hABCD);
    // CD leaves before AB
    read_word();
    read_word();
    check_bit("empty_o", empty_o, 1'b1);
  endtask

  task automatic test_fill_and_block();
    for (int i = 0; i < DEPTH_UNITS / W_UNITS; i++) begin
      write_word(16'h1100 + 16'(i * 16'h0101));
    end
    check_bit("full_o", full_o, 1'b1);
    expect_no_write_ack(16'h5A5A);
  endtask

  task automatic test_drain();
    while (byte_q.size() > 0) begin
      read_word();
    end
    check_bit("empty_o", empty_o, 1'b1);
  endtask

  task automatic test_random_ops();
    logic [31:0] pick;
    logic [31:0] rnd;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      pick = $urandom;
      rnd = $urandom;
      if (pick[0]) begin
        if ((DEPTH_UNITS - byte_q.size()) >= W_UNITS) begin
          write_word(rnd[`ASYM_W_DATA_W-1:0]);
        end
      end else if (byte_q.size() > 0) begin
        read_word();
      end
    end
  endtask

  initial begin
    void'($urandom(32'hd79f_fa67));
    rst_n_i = 1'b0;
    wr_req_i = 1'b0;
    wr_data_i = '0;
    rd_req_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    step();

    test_reset_state();
    test_single_word();
    test_fill_and_block();
    test_drain();
    test_random_ops();

    $display("TESTS PASSED");
    $finish;
  end

endmodule
